/* flist.f */
verilog/mesh_bridge_pkg.sv
verilog/mesh_link_if.sv
verilog/credit_fifo.sv
verilog/mesh_endpoint.sv
verilog/host_rx_arbiter.sv
verilog/mesh_bridge_top.sv
testbench/tb_mesh_bridge.sv

/* testbench/tb_mesh_bridge.sv */
`timescale 1ns/1ps

module tb_mesh_bridge;

   import mesh_bridge_pkg::*;

   logic               clk_i;
   logic               rst_ni;
   logic [COORD_W-1:0] my_x_i;
   logic [COORD_W-1:0] my_y_i;
   logic               host_req_v_i;
   pkt_op_e            host_req_op_i;
   logic [COORD_W-1:0] host_req_dst_x_i;
   logic [COORD_W-1:0] host_req_dst_y_i;
   logic [ADDR_W-1:0]  host_req_addr_i;
   logic [DATA_W-1:0]  host_req_data_i;
   logic               host_req_ready_o;
   logic               link_out_v_o;
   mesh_pkt_t          link_out_pkt_o;
   logic               link_out_credit_i;
   logic               link_in_v_i;
   mesh_pkt_t          link_in_pkt_i;
   logic               link_in_req_credit_o;
   logic               link_in_rsp_credit_o;
   logic               host_rx_v_o;
   logic               host_rx_is_rsp_o;
   mesh_pkt_t          host_rx_pkt_o;
   logic               host_rx_ready_i;
   logic [CREDIT_W-1:0] host_out_credits_o;

   // Mesh model and host driver state
   int host_left;
   int host_acc;
   int inj_left;
   int req_sent;
   int rsp_sent;
   int link_returned;
   int ready_hold;
   bit link_ret_en;
   bit rsp_only;
   bit auto_rsp;
   bit rx_ready_random;

   // Expected state of the comparing process
   mesh_pkt_t link_q[$];
   mesh_pkt_t req_q[$];
   mesh_pkt_t rsp_q[$];
   int        link_rcvd;
   int        req_cred_back;
   int        rsp_cred_back;
   int        exp_out_credits;
   int        exp_link_credits;
   logic      exp_req_credit;
   logic      exp_rsp_credit;
   logic      last_rsp;

   mesh_bridge_top mesh_bridge_top_inst (
      .clk_i                (clk_i),
      .rst_ni               (rst_ni),
      .my_x_i               (my_x_i),
      .my_y_i               (my_y_i),
      .host_req_v_i         (host_req_v_i),
      .host_req_op_i        (host_req_op_i),
      .host_req_dst_x_i     (host_req_dst_x_i),
      .host_req_dst_y_i     (host_req_dst_y_i),
      .host_req_addr_i      (host_req_addr_i),
      .host_req_data_i      (host_req_data_i),
      .host_req_ready_o     (host_req_ready_o),
      .link_out_v_o         (link_out_v_o),
      .link_out_pkt_o       (link_out_pkt_o),
      .link_out_credit_i    (link_out_credit_i),
      .link_in_v_i          (link_in_v_i),
      .link_in_pkt_i        (link_in_pkt_i),
      .link_in_req_credit_o (link_in_req_credit_o),
      .link_in_rsp_credit_o (link_in_rsp_credit_o),
      .host_rx_v_o          (host_rx_v_o),
      .host_rx_is_rsp_o     (host_rx_is_rsp_o),
      .host_rx_pkt_o        (host_rx_pkt_o),
      .host_rx_ready_i      (host_rx_ready_i),
      .host_out_credits_o   (host_out_credits_o)
   );

   always #50 clk_i = ~clk_i;

   // ------------------------------
   // Reference model
   // ------------------------------
   function automatic mesh_pkt_t expected_link_pkt(input pkt_op_e op,
         input logic [COORD_W-1:0] src_x, input logic [COORD_W-1:0] src_y,
         input logic [COORD_W-1:0] dst_x, input logic [COORD_W-1:0] dst_y,
         input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      mesh_pkt_t pkt;
      pkt.kind  = KIND_REQ;
      pkt.op    = op;
      pkt.src_x = src_x;
      pkt.src_y = src_y;
      pkt.dst_x = dst_x;
      pkt.dst_y = dst_y;
      pkt.addr  = addr;
      pkt.data  = data;
      return pkt;
   endfunction

   // A response reaches the host without destination and address
   function automatic mesh_pkt_t expected_rx_pkt(input mesh_pkt_t in_pkt);
      mesh_pkt_t pkt;
      pkt = in_pkt;
      if (in_pkt.kind == KIND_RSP) begin
         pkt.dst_x = '0;
         pkt.dst_y = '0;
         pkt.addr  = '0;
      end
      return pkt;
   endfunction

   function automatic mesh_pkt_t random_in_pkt(input logic is_rsp);
      mesh_pkt_t pkt;
      pkt.kind  = is_rsp ? KIND_RSP : KIND_REQ;
      pkt.op    = pkt_op_e'($urandom_range(1));
      pkt.src_x = COORD_W'($urandom);
      pkt.src_y = COORD_W'($urandom);
      pkt.dst_x = COORD_W'($urandom);
      pkt.dst_y = COORD_W'($urandom);
      pkt.addr  = ADDR_W'($urandom);
      pkt.data  = $urandom;
      return pkt;
   endfunction

   task automatic check_value(input string name, input logic [63:0] exp_val,
         input logic [63:0] act_val);
      if (exp_val !== act_val) begin
         $display("Fail %s: expected %h, actual %h", name, exp_val, act_val);
         $display("SIMULATION FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout: %s", what);
      $display("SIMULATION FAILED");
      $fatal(1, "wait timed out");
   endtask

   // ------------------------------
   // Comparing process
   // ------------------------------
   always @(negedge clk_i) begin : scoreboard
      mesh_pkt_t exp_pkt;
      logic      exp_ready;
      logic      exp_is_rsp;
      logic      popped_req;
      logic      popped_rsp;
      logic      accept;
      logic      rsp_arrive;
      if (!rst_ni) begin
         link_q.delete();
         req_q.delete();
         rsp_q.delete();
         link_rcvd        = 0;
         req_cred_back    = 0;
         rsp_cred_back    = 0;
         exp_out_credits  = MAX_OUT_CREDITS;
         exp_link_credits = LINK_CREDITS;
         exp_req_credit   = 1'b0;
         exp_rsp_credit   = 1'b0;
         // Requests win the first tie
         last_rsp         = 1'b1;
      end else begin
         exp_ready = (exp_out_credits > 0) && (exp_link_credits > 0);
         check_value("host_out_credits", exp_out_credits, host_out_credits_o);
         check_value("host_req_ready", exp_ready, host_req_ready_o);
         check_value("link_in_req_credit", exp_req_credit, link_in_req_credit_o);
         check_value("link_in_rsp_credit", exp_rsp_credit, link_in_rsp_credit_o);

         // One cycle from acceptance to the link
         check_value("link_out_v", link_q.size() != 0, link_out_v_o);
         if (link_out_v_o) begin
            check_value("link_out_pkt", link_q.pop_front(), link_out_pkt_o);
            link_rcvd++;
         end

         // Host receive port against the per-class queues
         check_value("host_rx_v", (req_q.size() != 0) || (rsp_q.size() != 0), host_rx_v_o);
         popped_req = 1'b0;
         popped_rsp = 1'b0;
         if (host_rx_v_o && host_rx_ready_i) begin
            if (req_q.size() != 0 && rsp_q.size() != 0) begin
               exp_is_rsp = !last_rsp;
            end else begin
               exp_is_rsp = (rsp_q.size() != 0);
            end
            check_value("host_rx_is_rsp", exp_is_rsp, host_rx_is_rsp_o);
            if (exp_is_rsp) begin
               exp_pkt    = rsp_q.pop_front();
               popped_rsp = 1'b1;
            end else begin
               exp_pkt    = req_q.pop_front();
               popped_req = 1'b1;
            end
            check_value("host_rx_pkt", exp_pkt, host_rx_pkt_o);
            last_rsp = exp_is_rsp;
         end

         if (link_in_req_credit_o) begin
            req_cred_back++;
         end
         if (link_in_rsp_credit_o) begin
            rsp_cred_back++;
         end
         exp_req_credit = popped_req;
         exp_rsp_credit = popped_rsp;

         // Inputs taken at the coming edge
         rsp_arrive = 1'b0;
         if (link_in_v_i) begin
            if (link_in_pkt_i.kind == KIND_RSP) begin
               rsp_q.push_back(expected_rx_pkt(link_in_pkt_i));
               rsp_arrive = 1'b1;
            end else begin
               req_q.push_back(expected_rx_pkt(link_in_pkt_i));
            end
         end
         accept = host_req_v_i && exp_ready;
         if (accept) begin
            link_q.push_back(expected_link_pkt(host_req_op_i, my_x_i, my_y_i,
               host_req_dst_x_i, host_req_dst_y_i, host_req_addr_i, host_req_data_i));
            exp_out_credits--;
            exp_link_credits--;
         end
         if (rsp_arrive) begin
            exp_out_credits++;
         end
         if (link_out_credit_i) begin
            exp_link_credits++;
         end
      end
   end

   // ------------------------------
   // Stimulus and mesh model
   // ------------------------------
   task automatic advance_cycle();
      logic acc;
      int   outstanding;
      bit   req_ok;
      bit   rsp_ok;
      bit   pick_rsp;
      @(negedge clk_i);
      acc = host_req_v_i && host_req_ready_o;
      @(posedge clk_i);
      #1;
      if (acc) begin
         host_acc++;
         host_left--;
      end

      // New request fields only once the previous one was taken
      if (host_left == 0) begin
         host_req_v_i = 1'b0;
      end else if (acc || !host_req_v_i) begin
         host_req_v_i     = 1'b1;
         host_req_op_i    = pkt_op_e'($urandom_range(1));
         host_req_dst_x_i = COORD_W'($urandom);
         host_req_dst_y_i = COORD_W'($urandom);
         host_req_addr_i  = ADDR_W'($urandom);
         host_req_data_i  = $urandom;
      end

      link_out_credit_i = 1'b0;
      if (link_ret_en && (link_rcvd > link_returned) && ($urandom_range(1) == 1)) begin
         link_out_credit_i = 1'b1;
         link_returned++;
      end

      // Mesh sends only within its per-class credits
      link_in_v_i = 1'b0;
      outstanding = host_acc - rsp_sent;
      req_ok = (inj_left > 0) && !rsp_only && (req_sent - req_cred_back < RX_DEPTH);
      rsp_ok = (inj_left > 0 || auto_rsp) && (outstanding > 0)
               && (rsp_sent - rsp_cred_back < RX_DEPTH);
      if ((req_ok || rsp_ok) && ($urandom_range(3) != 0)) begin
         pick_rsp      = rsp_ok && (!req_ok || ($urandom_range(1) == 1));
         link_in_pkt_i = random_in_pkt(pick_rsp);
         link_in_v_i   = 1'b1;
         if (pick_rsp) begin
            rsp_sent++;
         end else begin
            req_sent++;
         end
         if (inj_left > 0) begin
            inj_left--;
         end
      end

      if (!rx_ready_random) begin
         host_rx_ready_i = 1'b1;
      end else if (ready_hold == 0) begin
         host_rx_ready_i = ($urandom_range(1) == 1);
         ready_hold      = $urandom_range(6, 1);
      end else begin
         ready_hold--;
      end
   endtask

   // Answers every outstanding request and empties both queues
   task automatic drain_traffic(input string phase);
      int cycles;
      cycles          = 0;
      auto_rsp        = 1'b1;
      link_ret_en     = 1'b1;
      rx_ready_random = 1'b0;
      while (host_left > 0 || inj_left > 0 || host_acc != rsp_sent
             || link_rcvd != link_returned || req_q.size() != 0 || rsp_q.size() != 0
             || req_cred_back != req_sent || rsp_cred_back != rsp_sent) begin
         advance_cycle();
         cycles++;
         if (cycles > 3000) begin
            report_timeout({"traffic never drained after the ", phase});
         end
      end
      auto_rsp = 1'b0;
   endtask

   initial begin
      int seed_value;
      int base;
      int cycles;
      seed_value = $urandom(32'ha37f7077);
      clk_i             = 1'b0;
      rst_ni            = 1'b0;
      my_x_i            = COORD_W'($urandom);
      my_y_i            = COORD_W'($urandom);
      host_req_v_i      = 1'b0;
      host_req_op_i     = OP_LOAD;
      host_req_dst_x_i  = '0;
      host_req_dst_y_i  = '0;
      host_req_addr_i   = '0;
      host_req_data_i   = '0;
      link_out_credit_i = 1'b0;
      link_in_v_i       = 1'b0;
      link_in_pkt_i     = '0;
      host_rx_ready_i   = 1'b1;
      host_left = 0;
      host_acc = 0;
      inj_left = 0;
      req_sent = 0;
      rsp_sent = 0;
      link_returned = 0;
      ready_hold = 0;
      link_ret_en = 1'b1;
      rsp_only = 1'b0;
      auto_rsp = 1'b0;
      rx_ready_random = 1'b0;

      repeat (3) @(posedge clk_i);
      #1;
      rst_ni = 1'b1;

      @(negedge clk_i);
      check_value("reset_link_out_v", 0, link_out_v_o);
      check_value("reset_host_rx_v", 0, host_rx_v_o);
      check_value("reset_req_credit", 0, link_in_req_credit_o);
      check_value("reset_rsp_credit", 0, link_in_rsp_credit_o);
      check_value("reset_out_credits", MAX_OUT_CREDITS, host_out_credits_o);

      // Forwarding up to the out-credit limit with no responses
      host_left = 12;
      cycles    = 0;
      while (host_acc < MAX_OUT_CREDITS) begin
         advance_cycle();
         cycles++;
         if (cycles > 200) begin
            report_timeout("the first eight host requests were never accepted");
         end
      end
      repeat (20) advance_cycle();
      check_value("out_credit_limit", MAX_OUT_CREDITS, host_acc);

      // Each response frees room for one more request
      rsp_only = 1'b1;
      inj_left = 3;
      cycles   = 0;
      while (host_acc < MAX_OUT_CREDITS + 3) begin
         advance_cycle();
         cycles++;
         if (cycles > 200) begin
            report_timeout("responses never re-enabled host requests");
         end
      end
      rsp_only = 1'b0;
      drain_traffic("out-credit test");

      // Withheld link credits stall the outgoing link
      link_ret_en = 1'b0;
      base        = host_acc;
      host_left   = 6;
      cycles      = 0;
      while (host_acc - base < LINK_CREDITS) begin
         advance_cycle();
         cycles++;
         if (cycles > 200) begin
            report_timeout("four host requests never left on the link");
         end
      end
      repeat (20) advance_cycle();
      check_value("link_stall_accepts", LINK_CREDITS, host_acc - base);
      check_value("link_stall_in_flight", LINK_CREDITS, link_rcvd - link_returned);
      drain_traffic("link-credit test");

      // Mixed receive traffic with the host always ready
      host_left = 40;
      inj_left  = 80;
      cycles    = 0;
      while (inj_left > 0) begin
         advance_cycle();
         cycles++;
         if (cycles > 2000) begin
            report_timeout("incoming packets were never all injected");
         end
      end
      drain_traffic("receive test");

      // Same again with random stretches of host back-pressure
      rx_ready_random = 1'b1;
      host_left       = 40;
      inj_left        = 120;
      cycles          = 0;
      while (inj_left > 0) begin
         advance_cycle();
         cycles++;
         if (cycles > 4000) begin
            report_timeout("incoming packets under back-pressure were never all injected");
         end
      end
      drain_traffic("back-pressure test");

      @(negedge clk_i);
      check_value("final_out_credits", MAX_OUT_CREDITS, host_out_credits_o);
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

/* verilog/credit_fifo.sv */
`timescale 1ns/1ps

module credit_fifo #(
   parameter type payload_t = logic,
   parameter int  DEPTH = mesh_bridge_pkg::RX_DEPTH
) (
   input  logic     clk_i,
   input  logic     rst_ni,
   mesh_link_if.rx  in_rx,
   output logic     out_v_o,
   output payload_t out_payload_o,
   input  logic     pop_i
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t   mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             credit_q;
   logic             push;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // The sender only pushes while it holds a credit, so no full check
   assign push = in_rx.v;

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem[wr_ptr_q] <= in_rx.payload;
      end
   end

   // ------------------------------
   // Pointers and occupancy
   // ------------------------------
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= next_ptr(wr_ptr_q);
         end
         if (pop_i) begin
            rd_ptr_q <= next_ptr(rd_ptr_q);
         end
         if (push && !pop_i) begin
            count_q <= count_q + 1'b1;
         end else if (pop_i && !push) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

   // Freed slot goes back to the sender one cycle after the pop
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         credit_q <= 1'b0;
      end else begin
         credit_q <= pop_i;
      end
   end

   assign in_rx.credit  = credit_q;
   assign out_v_o       = (count_q != '0);
   assign out_payload_o = mem[rd_ptr_q];

endmodule

/* verilog/host_rx_arbiter.sv */
`timescale 1ns/1ps

module host_rx_arbiter (
   input  logic                       clk_i,
   input  logic                       rst_ni,

   // Request queue
   input  logic                       req_v_i,
   input  mesh_bridge_pkg::mesh_req_t req_pkt_i,
   output logic                       req_pop_o,

   // Response queue
   input  logic                       rsp_v_i,
   input  mesh_bridge_pkg::mesh_rsp_t rsp_pkt_i,
   output logic                       rsp_pop_o,

   // Host receive port
   output logic                       host_rx_v_o,
   output logic                       host_rx_is_rsp_o,
   output mesh_bridge_pkg::mesh_pkt_t host_rx_pkt_o,
   input  logic                       host_rx_ready_i
);

   import mesh_bridge_pkg::*;

   logic last_rsp_q;
   logic grant_rsp;
   logic handshake;

   // Response wins when alone or when requests were served last
   assign grant_rsp = rsp_v_i && (!req_v_i || !last_rsp_q);

   assign host_rx_v_o      = req_v_i || rsp_v_i;
   assign host_rx_is_rsp_o = grant_rsp;
   assign handshake        = host_rx_v_o && host_rx_ready_i;

   assign req_pop_o = handshake && !grant_rsp;
   assign rsp_pop_o = handshake && grant_rsp;

   // Start as if a response was served, so requests win the first tie
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         last_rsp_q <= 1'b1;
      end else if (handshake) begin
         last_rsp_q <= grant_rsp;
      end
   end

   // ------------------------------
   // Packet rebuild
   // ------------------------------
   // Fields a response does not carry come back as zero
   always_comb begin
      host_rx_pkt_o = '0;
      if (grant_rsp) begin
         host_rx_pkt_o.kind  = KIND_RSP;
         host_rx_pkt_o.op    = rsp_pkt_i.op;
         host_rx_pkt_o.src_x = rsp_pkt_i.src_x;
         host_rx_pkt_o.src_y = rsp_pkt_i.src_y;
         host_rx_pkt_o.data  = rsp_pkt_i.data;
      end else begin
         host_rx_pkt_o.kind  = KIND_REQ;
         host_rx_pkt_o.op    = req_pkt_i.op;
         host_rx_pkt_o.src_x = req_pkt_i.src_x;
         host_rx_pkt_o.src_y = req_pkt_i.src_y;
         host_rx_pkt_o.dst_x = req_pkt_i.dst_x;
         host_rx_pkt_o.dst_y = req_pkt_i.dst_y;
         host_rx_pkt_o.addr  = req_pkt_i.addr;
         host_rx_pkt_o.data  = req_pkt_i.data;
      end
   end

endmodule

/* verilog/mesh_bridge_pkg.sv */
package mesh_bridge_pkg;

   // ------------------------------
   // Widths
   // ------------------------------
   localparam int COORD_W = 4;
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;

   // ------------------------------
   // Credits and depths
   // ------------------------------
   // Host requests allowed in flight without a response
   localparam int MAX_OUT_CREDITS = 8;

   // Buffer slots the mesh grants on the outgoing link
   localparam int LINK_CREDITS = 4;

   // Depth of each receive queue, also the mesh's initial credit per class
   localparam int RX_DEPTH = 4;

   localparam int CREDIT_W = $clog2(MAX_OUT_CREDITS + 1);
   localparam int LINK_CREDIT_W = $clog2(LINK_CREDITS + 1);

   // ------------------------------
   // Packet types
   // ------------------------------
   typedef enum logic {
      OP_LOAD  = 1'b0,
      OP_STORE = 1'b1
   } pkt_op_e;

   typedef enum logic {
      KIND_REQ = 1'b0,
      KIND_RSP = 1'b1
   } pkt_kind_e;

   // Full packet as it travels on a link
   typedef struct packed {
      pkt_kind_e          kind;
      pkt_op_e            op;
      logic [COORD_W-1:0] src_x;
      logic [COORD_W-1:0] src_y;
      logic [COORD_W-1:0] dst_x;
      logic [COORD_W-1:0] dst_y;
      logic [ADDR_W-1:0]  addr;
      logic [DATA_W-1:0]  data;
   } mesh_pkt_t;

   // Request queue entry, the kind is implied by the queue
   typedef struct packed {
      pkt_op_e            op;
      logic [COORD_W-1:0] src_x;
      logic [COORD_W-1:0] src_y;
      logic [COORD_W-1:0] dst_x;
      logic [COORD_W-1:0] dst_y;
      logic [ADDR_W-1:0]  addr;
      logic [DATA_W-1:0]  data;
   } mesh_req_t;

   // Response queue entry, no address and no destination
   typedef struct packed {
      pkt_op_e            op;
      logic [COORD_W-1:0] src_x;
      logic [COORD_W-1:0] src_y;
      logic [DATA_W-1:0]  data;
   } mesh_rsp_t;

endpackage

/* verilog/mesh_bridge_top.sv */
`timescale 1ns/1ps

module mesh_bridge_top (
   input  logic                                 clk_i,
   input  logic                                 rst_ni,
   input  logic [mesh_bridge_pkg::COORD_W-1:0]  my_x_i,
   input  logic [mesh_bridge_pkg::COORD_W-1:0]  my_y_i,

   // Host request port
   input  logic                                 host_req_v_i,
   input  mesh_bridge_pkg::pkt_op_e             host_req_op_i,
   input  logic [mesh_bridge_pkg::COORD_W-1:0]  host_req_dst_x_i,
   input  logic [mesh_bridge_pkg::COORD_W-1:0]  host_req_dst_y_i,
   input  logic [mesh_bridge_pkg::ADDR_W-1:0]   host_req_addr_i,
   input  logic [mesh_bridge_pkg::DATA_W-1:0]   host_req_data_i,
   output logic                                 host_req_ready_o,

   // Outgoing mesh link
   output logic                                 link_out_v_o,
   output mesh_bridge_pkg::mesh_pkt_t           link_out_pkt_o,
   input  logic                                 link_out_credit_i,

   // Incoming mesh link
   input  logic                                 link_in_v_i,
   input  mesh_bridge_pkg::mesh_pkt_t           link_in_pkt_i,
   output logic                                 link_in_req_credit_o,
   output logic                                 link_in_rsp_credit_o,

   // Host receive port
   output logic                                 host_rx_v_o,
   output logic                                 host_rx_is_rsp_o,
   output mesh_bridge_pkg::mesh_pkt_t           host_rx_pkt_o,
   input  logic                                 host_rx_ready_i,

   output logic [mesh_bridge_pkg::CREDIT_W-1:0] host_out_credits_o
);

   import mesh_bridge_pkg::*;

   mesh_link_if #(.payload_t(mesh_req_t)) req_link ();
   mesh_link_if #(.payload_t(mesh_rsp_t)) rsp_link ();

   // Queue heads toward the arbiter
   logic      req_q_v;
   mesh_req_t req_q_pkt;
   logic      req_q_pop;
   logic      rsp_q_v;
   mesh_rsp_t rsp_q_pkt;
   logic      rsp_q_pop;

   mesh_endpoint endpoint_inst (
      .clk_i                (clk_i),
      .rst_ni               (rst_ni),
      .my_x_i               (my_x_i),
      .my_y_i               (my_y_i),
      .host_req_v_i         (host_req_v_i),
      .host_req_op_i        (host_req_op_i),
      .host_req_dst_x_i     (host_req_dst_x_i),
      .host_req_dst_y_i     (host_req_dst_y_i),
      .host_req_addr_i      (host_req_addr_i),
      .host_req_data_i      (host_req_data_i),
      .host_req_ready_o     (host_req_ready_o),
      .link_out_v_o         (link_out_v_o),
      .link_out_pkt_o       (link_out_pkt_o),
      .link_out_credit_i    (link_out_credit_i),
      .link_in_v_i          (link_in_v_i),
      .link_in_pkt_i        (link_in_pkt_i),
      .req_tx               (req_link.tx),
      .rsp_tx               (rsp_link.tx),
      .link_in_req_credit_o (link_in_req_credit_o),
      .link_in_rsp_credit_o (link_in_rsp_credit_o),
      .host_out_credits_o   (host_out_credits_o)
   );

   // ------------------------------
   // Receive queues
   // ------------------------------
   credit_fifo #(
      .payload_t (mesh_req_t),
      .DEPTH     (RX_DEPTH)
   ) req_fifo_inst (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .in_rx         (req_link.rx),
      .out_v_o       (req_q_v),
      .out_payload_o (req_q_pkt),
      .pop_i         (req_q_pop)
   );

   credit_fifo #(
      .payload_t (mesh_rsp_t),
      .DEPTH     (RX_DEPTH)
   ) rsp_fifo_inst (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .in_rx         (rsp_link.rx),
      .out_v_o       (rsp_q_v),
      .out_payload_o (rsp_q_pkt),
      .pop_i         (rsp_q_pop)
   );

   host_rx_arbiter arbiter_inst (
      .clk_i            (clk_i),
      .rst_ni           (rst_ni),
      .req_v_i          (req_q_v),
      .req_pkt_i        (req_q_pkt),
      .req_pop_o        (req_q_pop),
      .rsp_v_i          (rsp_q_v),
      .rsp_pkt_i        (rsp_q_pkt),
      .rsp_pop_o        (rsp_q_pop),
      .host_rx_v_o      (host_rx_v_o),
      .host_rx_is_rsp_o (host_rx_is_rsp_o),
      .host_rx_pkt_o    (host_rx_pkt_o),
      .host_rx_ready_i  (host_rx_ready_i)
   );

endmodule

/* verilog/mesh_endpoint.sv */
`timescale 1ns/1ps

module mesh_endpoint (
   input  logic                                 clk_i,
   input  logic                                 rst_ni,
   input  logic [mesh_bridge_pkg::COORD_W-1:0]  my_x_i,
   input  logic [mesh_bridge_pkg::COORD_W-1:0]  my_y_i,

   // Host requests toward the mesh
   input  logic                                 host_req_v_i,
   input  mesh_bridge_pkg::pkt_op_e             host_req_op_i,
   input  logic [mesh_bridge_pkg::COORD_W-1:0]  host_req_dst_x_i,
   input  logic [mesh_bridge_pkg::COORD_W-1:0]  host_req_dst_y_i,
   input  logic [mesh_bridge_pkg::ADDR_W-1:0]   host_req_addr_i,
   input  logic [mesh_bridge_pkg::DATA_W-1:0]   host_req_data_i,
   output logic                                 host_req_ready_o,

   // Outgoing link
   output logic                                 link_out_v_o,
   output mesh_bridge_pkg::mesh_pkt_t           link_out_pkt_o,
   input  logic                                 link_out_credit_i,

   // Incoming link
   input  logic                                 link_in_v_i,
   input  mesh_bridge_pkg::mesh_pkt_t           link_in_pkt_i,
   mesh_link_if.tx                              req_tx,
   mesh_link_if.tx                              rsp_tx,
   output logic                                 link_in_req_credit_o,
   output logic                                 link_in_rsp_credit_o,

   output logic [mesh_bridge_pkg::CREDIT_W-1:0] host_out_credits_o
);

   import mesh_bridge_pkg::*;

   logic                     accept;
   logic                     rsp_arrive;
   logic                     in_is_rsp;
   logic [CREDIT_W-1:0]      out_credits_q;
   logic [LINK_CREDIT_W-1:0] link_credits_q;
   logic                     link_out_v_q;
   mesh_pkt_t                out_pkt_d;
   mesh_pkt_t                link_out_pkt_q;
   mesh_req_t                in_req;
   mesh_rsp_t                in_rsp;

   // ------------------------------
   // Host to mesh
   // ------------------------------
   assign host_req_ready_o = (out_credits_q != '0) && (link_credits_q != '0);
   assign accept = host_req_v_i && host_req_ready_o;

   // Our own coordinates become the source
   always_comb begin
      out_pkt_d.kind  = KIND_REQ;
      out_pkt_d.op    = host_req_op_i;
      out_pkt_d.src_x = my_x_i;
      out_pkt_d.src_y = my_y_i;
      out_pkt_d.dst_x = host_req_dst_x_i;
      out_pkt_d.dst_y = host_req_dst_y_i;
      out_pkt_d.addr  = host_req_addr_i;
      out_pkt_d.data  = host_req_data_i;
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         link_out_v_q <= 1'b0;
      end else begin
         link_out_v_q <= accept;
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         link_out_pkt_q <= out_pkt_d;
      end
   end

   assign link_out_v_o   = link_out_v_q;
   assign link_out_pkt_o = link_out_pkt_q;

   // ------------------------------
   // Credit counters
   // ------------------------------
   // Spend and return in the same cycle cancel out
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         out_credits_q <= CREDIT_W'(MAX_OUT_CREDITS);
      end else if (accept && !rsp_arrive) begin
         out_credits_q <= out_credits_q - 1'b1;
      end else if (rsp_arrive && !accept) begin
         out_credits_q <= out_credits_q + 1'b1;
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         link_credits_q <= LINK_CREDIT_W'(LINK_CREDITS);
      end else if (accept && !link_out_credit_i) begin
         link_credits_q <= link_credits_q - 1'b1;
      end else if (link_out_credit_i && !accept) begin
         link_credits_q <= link_credits_q + 1'b1;
      end
   end

   assign host_out_credits_o = out_credits_q;

   // ------------------------------
   // Mesh to host steering
   // ------------------------------
   assign in_is_rsp  = (link_in_pkt_i.kind == KIND_RSP);
   assign rsp_arrive = link_in_v_i && in_is_rsp;

   always_comb begin
      in_req.op    = link_in_pkt_i.op;
      in_req.src_x = link_in_pkt_i.src_x;
      in_req.src_y = link_in_pkt_i.src_y;
      in_req.dst_x = link_in_pkt_i.dst_x;
      in_req.dst_y = link_in_pkt_i.dst_y;
      in_req.addr  = link_in_pkt_i.addr;
      in_req.data  = link_in_pkt_i.data;
   end

   // Responses are addressed to us, so only the source is kept
   always_comb begin
      in_rsp.op    = link_in_pkt_i.op;
      in_rsp.src_x = link_in_pkt_i.src_x;
      in_rsp.src_y = link_in_pkt_i.src_y;
      in_rsp.data  = link_in_pkt_i.data;
   end

   assign req_tx.v       = link_in_v_i && !in_is_rsp;
   assign req_tx.payload = in_req;
   assign rsp_tx.v       = rsp_arrive;
   assign rsp_tx.payload = in_rsp;

   // Queue credits go straight back to the mesh
   assign link_in_req_credit_o = req_tx.credit;
   assign link_in_rsp_credit_o = rsp_tx.credit;

endmodule

/* verilog/mesh_link_if.sv */
`timescale 1ns/1ps

// One direction of a credit-flow link
interface mesh_link_if #(
   parameter type payload_t = logic
);

   // Sender side
   logic     v;
   payload_t payload;

   // Receiver side, one pulse per freed slot
   logic     credit;

   modport tx (
      output v,
      output payload,
      input  credit
   );

   modport rx (
      input  v,
      input  payload,
      output credit
   );

endinterface
